// ==== project.f ====
source/cart_pkg.sv
source/cart_bus_front.sv
source/game_ram.sv
source/sector_loader.sv
source/status_leds.sv
source/cart_top.sv
test/cart_sva.sv
test/cart_tb.sv

// ==== test/cart_tests.txt ====
// One bus operation per line: kind address data expected
// Kinds: 1 read (expected d), 2 trigger write (expected led[5]), 3 write (expected buf_oe),
//        4 wait for load (data = sector count), 0 end
// Menu mode reads while loading runs
1 4000 00 ff
1 ffff 00 ff
1 8000 00 ff
// Trigger is ignored before the image is complete
2 0458 80 01
3 0452 5a 00
3 2200 01 01
4 0000 61 00
// Trigger needs bit 7
2 0458 00 01
2 0458 7f 01
2 0458 80 00
// Game mode reads, value = low byte of sector*13 + byte index
1 4000 00 80
1 4001 00 81
1 407f 00 ff
1 4080 00 00
1 417f 00 ff
1 4180 00 0d
1 4181 00 0e
1 5234 00 29
1 8000 00 20
1 c123 00 e3
1 ff7f 00 d2
1 ff80 00 e0
1 ffff 00 5f
// POKEY write opens the buffer, menu byte does not
3 0452 5a 00
3 2200 01 01
0 0000 00 00

// ==== test/cart_tb.sv ====
`timescale 1ns/1ns

module cart_tb;
    import cart_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 5;        // Inputs change after the edge
    localparam int NUM_OPS      = 26;       // Lines in the tests file
    localparam int LOAD_TIMEOUT = 400000;   // Cycles for the whole image
    localparam int BUS_TIMEOUT  = 8;
    localparam int SD_TIMEOUT   = 64;
    localparam int WRITE_HOLD   = 4;        // Bus write length in cycles

    logic        sys_clk;
    logic        sd_reset;
    logic [15:0] a;
    logic        phi2;
    logic        rw;
    logic        halt;
    wire  [7:0]  d;
    logic [7:0]  d_drive;      // Console side of d
    logic        d_drive_en;
    logic        buf_dir;
    logic        buf_oe;
    logic        sd_rd;
    logic [31:0] sd_address;
    logic        sd_ready;
    logic [4:0]  sd_status;
    logic [7:0]  sd_dout;
    logic        sd_byte_available;
    logic [5:0]  led;

    logic [15:0] test_words [0:4*NUM_OPS-1];   // kind, addr, data, expected
    int          error_count;
    int          check_count;
    int          sector_requests;
    int          seed_init;

    assign d = d_drive_en ? d_drive : 8'hzz;

    cart_top dut0 (
        .sys_clk(sys_clk), .sd_reset(sd_reset),
        .a(a), .phi2(phi2), .rw(rw), .halt(halt), .d(d),
        .buf_dir(buf_dir), .buf_oe(buf_oe),
        .sd_rd(sd_rd), .sd_address(sd_address), .sd_ready(sd_ready),
        .sd_status(sd_status), .sd_dout(sd_dout),
        .sd_byte_available(sd_byte_available), .led(led)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    // ==================================================
    // Helpers
    // ==================================================
    task automatic next_cycle();
        @(posedge sys_clk);
        #DRIVE_DELAY;   // Drive and sample point
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("Fail t=%0t %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    task automatic report_error(input string what);
        error_count++;
        $display("Error t=%0t %s", $time, what);
    endtask

    // Idle bus, then wait for the buffer to close
    task automatic release_bus();
        int waited;
        a = 16'h0000;
        rw = 1'b1;
        phi2 = 1'b0;
        halt = 1'b1;
        d_drive_en = 1'b0;
        waited = 0;
        next_cycle();
        while (buf_oe !== 1'b1 && waited < BUS_TIMEOUT) begin
            next_cycle();
            waited++;
        end
        assert (buf_oe === 1'b1)
            else report_error("bus buffer stayed enabled after the bus cycle");
    endtask

    task automatic read_cycle(input logic [15:0] addr, input logic [7:0] exp);
        int waited;
        a = addr;
        rw = 1'b1;
        phi2 = 1'b1;
        halt = 1'b1;
        waited = 0;
        next_cycle();
        while (buf_oe !== 1'b0 && waited < BUS_TIMEOUT) begin
            next_cycle();
            waited++;
        end
        assert (buf_oe === 1'b0)
            else report_error($sformatf("bus buffer never enabled for read at %h", addr));
        next_cycle();   // Data one cycle behind the buffer
        expect_equal("d", d, exp);
        expect_equal("buf_dir", buf_dir, 1'b1);
        expect_equal("buf_oe", buf_oe, 1'b0);
        release_bus();
    endtask

    // Lowest buf_oe seen while the console writes
    task automatic write_cycle(input logic [15:0] addr, input logic [7:0] data,
                               output logic oe_min);
        a = addr;
        rw = 1'b0;
        phi2 = 1'b1;
        halt = 1'b1;
        d_drive = data;
        d_drive_en = 1'b1;
        oe_min = 1'b1;
        repeat (WRITE_HOLD) begin
            next_cycle();
            oe_min = oe_min & buf_oe;
            expect_equal("d", d, data);   // No contention from the cart
        end
        expect_equal("buf_dir", buf_dir, 1'b0);   // Console to cart
        release_bus();
    endtask

    task automatic wait_game_led(input logic level);
        int waited;
        waited = 0;
        while (led[5] !== level && waited < BUS_TIMEOUT) begin
            next_cycle();
            waited++;
        end
        expect_equal("led[5]", led[5], level);
    endtask

    task automatic wait_for_load(input int sectors);
        int         waited;
        logic [6:0] last_sector;
        logic [2:0] sector_leds;
        waited = 0;
        last_sector = 7'(sectors - 1);
        sector_leds = ~last_sector[6:4];   // Progress LEDs are active low
        while (led[0] !== 1'b1 && waited < LOAD_TIMEOUT) begin
            next_cycle();
            waited++;
        end
        assert (led[0] === 1'b1)
            else report_error("game image load did not complete in time");
        expect_equal("sector requests", sector_requests, sectors);
        expect_equal("led[4:2]", led[4:2], sector_leds);
        expect_equal("led[1]", led[1], 1'b0);   // Bus cycles ran recently
    endtask

    // ==================================================
    // SD controller model
    // ==================================================
    task automatic serve_sd_requests();
        int          idle;
        int          byte_pos;
        int          gap;
        logic [31:0] sector;
        bit          running;
        running = 1'b1;
        while (running) begin
            idle = 0;
            while (sd_rd !== 1'b1 && idle < SD_TIMEOUT) begin
                next_cycle();
                idle++;
            end
            if (sd_rd !== 1'b1) begin
                running = 1'b0;   // Loader done asking
            end else begin
                sector = sd_address;
                expect_equal("sd_address", sd_address, sector_requests);
                sector_requests++;
                sd_ready = 1'b0;   // Busy
                idle = 0;
                next_cycle();
                while (sd_rd !== 1'b0 && idle < SD_TIMEOUT) begin
                    next_cycle();
                    idle++;
                end
                assert (sd_rd === 1'b0)
                    else report_error("sd_rd still high after the controller went busy");
                for (byte_pos = 0; byte_pos < SECTOR_BYTES; byte_pos++) begin
                    sd_dout = 8'(sector * 13 + byte_pos);
                    sd_byte_available = 1'b1;
                    next_cycle();
                    sd_byte_available = 1'b0;
                    gap = 1 + ($urandom % 4);   // 1 to 4 cycles
                    repeat (gap) next_cycle();
                end
                sd_ready = 1'b1;   // Sector done
                next_cycle();
            end
        end
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin : main_sequence
        int          op;
        bit          done;
        logic [15:0] kind;
        logic [15:0] addr;
        logic [15:0] data;
        logic [15:0] expected;
        logic        oe_min;
        error_count = 0;
        check_count = 0;
        sector_requests = 0;
        sd_reset = 1'b1;
        a = 16'h0000;
        phi2 = 1'b0;
        rw = 1'b1;
        halt = 1'b1;
        d_drive = 8'h00;
        d_drive_en = 1'b0;
        sd_ready = 1'b1;
        sd_status = SD_READY_STATUS;
        sd_dout = 8'h00;
        sd_byte_available = 1'b0;
        seed_init = $urandom(32'h7a91_d775);
        $readmemh("test/cart_tests.txt", test_words);

        repeat (2) @(posedge sys_clk);
        #DRIVE_DELAY;
        expect_equal("buf_oe", buf_oe, 1'b1);   // State right after reset
        expect_equal("sd_rd", sd_rd, 1'b0);
        expect_equal("led[5]", led[5], 1'b1);
        expect_equal("led[0]", led[0], 1'b0);
        expect_equal("led[1]", led[1], 1'b1);       // No console activity yet
        expect_equal("led[4:2]", led[4:2], 3'b111); // Sector 0
        sd_reset = 1'b0;

        fork
            serve_sd_requests();
        join_none

        op = 0;
        done = 1'b0;
        while (!done) begin
            kind     = test_words[4*op];
            addr     = test_words[4*op + 1];
            data     = test_words[4*op + 2];
            expected = test_words[4*op + 3];
            case (kind)
                16'h0: done = 1'b1;
                16'h1: read_cycle(addr, expected[7:0]);
                16'h2: begin
                    write_cycle(addr, data[7:0], oe_min);
                    wait_game_led(expected[0]);
                end
                16'h3: begin
                    write_cycle(addr, data[7:0], oe_min);
                    expect_equal("buf_oe", oe_min, expected[0]);
                end
                16'h4: wait_for_load(int'(data));
                default: begin
                    report_error($sformatf("unknown operation kind %h in tests file", kind));
                    done = 1'b1;
                end
            endcase
            op++;
            if (op >= NUM_OPS)
                done = 1'b1;
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== test/cart_sva.sv ====
`timescale 1ns/1ns

module cart_sva (
    input logic sys_clk,
    input logic sd_reset,
    input logic bus_write,      // Console write cycle at the pins
    input logic bus_drive,      // Cartridge drives d
    input logic wr_en,          // Game memory write strobe
    input logic loading_data,   // Loader collects sector bytes
    input logic game_loaded
);

    // ==================================================
    // Bus drive rules
    // ==================================================
    // Cart never fights the console on a write
    no_drive_on_write: assert property (
        @(posedge sys_clk) disable iff (sd_reset) bus_write |-> !bus_drive
    ) else $error("data bus driven during a console write cycle");

    // ==================================================
    // Loader rules
    // ==================================================
    write_only_in_data: assert property (
        @(posedge sys_clk) disable iff (sd_reset) wr_en |-> loading_data
    ) else $error("game memory written outside the sector data state");

    // Game mode is sticky until reset
    game_mode_sticky: assert property (
        @(posedge sys_clk) game_loaded && !sd_reset |=> game_loaded
    ) else $error("game mode left without a reset");

endmodule

bind cart_bus_front cart_sva bus_checks (
    .sys_clk(sys_clk), .sd_reset(sd_reset),
    .bus_write(!rw), .bus_drive(should_drive),
    .wr_en(1'b0), .loading_data(1'b1), .game_loaded(game_loaded)
);

bind sector_loader cart_sva loader_checks (
    .sys_clk(sys_clk), .sd_reset(sd_reset),
    .bus_write(1'b0), .bus_drive(1'b0),
    .wr_en(wr_en), .loading_data(state == cart_pkg::ld_data),
    .game_loaded(game_loaded)
);

// ==== source/cart_top.sv ====
`timescale 1ns/1ns

module cart_top (
    input  logic            sys_clk,
    input  logic            sd_reset,
    // Console bus
    input  cart_pkg::addr_t a,
    input  logic            phi2,
    input  logic            rw,
    input  logic            halt,
    inout  wire cart_pkg::byte_t d,
    output logic            buf_dir,
    output logic            buf_oe,
    // SD controller
    output logic            sd_rd,
    output logic [31:0]     sd_address,
    input  logic            sd_ready,
    input  logic [4:0]      sd_status,
    input  cart_pkg::byte_t sd_dout,
    input  logic            sd_byte_available,
    // Status
    output logic [5:0]      led
);
    import cart_pkg::*;

    // ==================================================
    // Internal wiring
    // ==================================================
    addr_t      a_safe;
    logic       rw_safe;
    logic       phi2_safe;
    byte_t      d_in;
    ram_index_t rom_index;
    byte_t      rd_data;
    logic       wr_en;
    ram_index_t wr_index;
    byte_t      wr_data;
    sector_t    current_sector;
    logic       load_done;
    logic       game_loaded;

    cart_bus_front u_front (
        .sys_clk(sys_clk), .sd_reset(sd_reset),
        .a(a), .phi2(phi2), .rw(rw), .halt(halt),
        .rd_data(rd_data), .game_loaded(game_loaded), .d(d),
        .a_safe(a_safe), .rw_safe(rw_safe), .phi2_safe(phi2_safe), .d_in(d_in),
        .rom_index(rom_index), .rom_read(),
        .buf_dir(buf_dir), .buf_oe(buf_oe)
    );

    game_ram u_ram (
        .sys_clk(sys_clk),
        .wr_en(wr_en), .wr_index(wr_index), .wr_data(wr_data),
        .rd_index(rom_index), .rd_data(rd_data)
    );

    sector_loader u_loader (
        .sys_clk(sys_clk), .sd_reset(sd_reset),
        .sd_ready(sd_ready), .sd_status(sd_status), .sd_dout(sd_dout),
        .sd_byte_available(sd_byte_available),
        .a_safe(a_safe), .rw_safe(rw_safe), .phi2_safe(phi2_safe), .d_in(d_in),
        .sd_rd(sd_rd), .sd_address(sd_address),
        .wr_en(wr_en), .wr_index(wr_index), .wr_data(wr_data),
        .current_sector(current_sector), .load_done(load_done),
        .game_loaded(game_loaded)
    );

    status_leds u_leds (
        .sys_clk(sys_clk), .sd_reset(sd_reset),
        .phi2_safe(phi2_safe), .load_done(load_done), .game_loaded(game_loaded),
        .current_sector(current_sector), .led(led)
    );

endmodule

// ==== source/status_leds.sv ====
`timescale 1ns/1ns

module status_leds (
    input  logic              sys_clk,
    input  logic              sd_reset,
    input  logic              phi2_safe,
    input  logic              load_done,
    input  logic              game_loaded,
    input  cart_pkg::sector_t current_sector,
    output logic [5:0]        led             // Active low
);
    import cart_pkg::*;

    logic        phi2_prev;
    logic        console_active;
    logic [20:0] activity_timer;   // Holds up to 2^20

    // ==================================================
    // Console activity detector
    // ==================================================
    // Any phi2 edge means the console is clocking, the flag decays after
    // the timeout once the clock stops
    always_ff @(posedge sys_clk) begin
        if (sd_reset) begin
            phi2_prev      <= 1'b0;
            console_active <= 1'b0;
            activity_timer <= '0;
        end else begin
            phi2_prev <= phi2_safe;
            if (phi2_safe != phi2_prev) begin
                console_active <= 1'b1;
                activity_timer <= 21'(ACTIVITY_TIMEOUT);
            end else if (activity_timer != '0) begin
                activity_timer <= activity_timer - 21'd1;
            end else begin
                console_active <= 1'b0;   // Timed out
            end
        end
    end

    // LED mapping
    assign led[0]   = load_done;              // On while loading
    assign led[1]   = ~console_active;        // On while console runs
    assign led[4:2] = ~current_sector[6:4];   // Coarse load progress
    assign led[5]   = ~game_loaded;           // On in game mode

endmodule

// ==== source/sector_loader.sv ====
`timescale 1ns/1ns

module sector_loader (
    input  logic                 sys_clk,
    input  logic                 sd_reset,
    input  logic                 sd_ready,
    input  logic [4:0]           sd_status,
    input  cart_pkg::byte_t      sd_dout,
    input  logic                 sd_byte_available,
    input  cart_pkg::addr_t      a_safe,
    input  logic                 rw_safe,
    input  logic                 phi2_safe,
    input  cart_pkg::byte_t      d_in,
    output logic                 sd_rd,
    output logic [31:0]          sd_address,
    output logic                 wr_en,
    output cart_pkg::ram_index_t wr_index,
    output cart_pkg::byte_t      wr_data,
    output cart_pkg::sector_t    current_sector,
    output logic                 load_done,
    output logic                 game_loaded
);
    import cart_pkg::*;

    loader_state_t state;

    logic [9:0]  byte_index;   // 0..512 within the sector
    logic        avail_d;      // Previous byte strobe level
    logic        byte_strobe;
    logic        keep_byte;
    logic [16:0] load_pos;     // Image offset of the current byte
    logic        trigger_wr;

    // ==================================================
    // Byte bookkeeping
    // ==================================================
    assign byte_strobe = sd_byte_available && !avail_d;   // One per byte

    // Sector 0 starts with the .a78 header
    assign keep_byte = (current_sector != '0) || (byte_index >= HEADER_BYTES);

    // s * 512 + i - 128, only meaningful when keep_byte is set
    assign load_pos = 17'({current_sector, 9'd0}) + 17'(byte_index)
                    - 17'(HEADER_BYTES);

    // Menu trigger write, value carries the magic bit 7
    assign trigger_wr = (a_safe == GAME_TRIGGER_ADDR) && !rw_safe && phi2_safe
                     && d_in[7];

    assign load_done = (state == ld_complete);

    // ==================================================
    // Loader FSM
    // ==================================================
    always_ff @(posedge sys_clk) begin
        if (sd_reset) begin
            state          <= ld_idle;
            sd_rd          <= 1'b0;
            sd_address     <= '0;
            byte_index     <= '0;
            avail_d        <= 1'b0;
            wr_en          <= 1'b0;
            current_sector <= '0;
            game_loaded    <= 1'b0;
        end else begin
            avail_d <= sd_byte_available;
            wr_en   <= 1'b0;   // Single-cycle write pulses

            case (state)
                ld_idle: begin
                    // Also the gap between sectors
                    if (sd_ready && (sd_status == SD_READY_STATUS))
                        state <= ld_start;
                end

                ld_start: begin
                    sd_address <= 32'(current_sector);
                    sd_rd      <= 1'b1;
                    byte_index <= '0;
                    state      <= ld_wait;
                end

                ld_wait: begin
                    if (!sd_ready) begin   // Controller accepted the read
                        sd_rd <= 1'b0;
                        state <= ld_data;
                    end
                end

                ld_data: begin
                    if (sd_ready) begin
                        // End of sector, or a short sector that is dropped
                        state <= ld_next;
                    end else if (byte_strobe && (byte_index < SECTOR_BYTES)) begin
                        if (keep_byte && (load_pos < ROM_BYTES)) begin
                            wr_en    <= 1'b1;
                            wr_index <= load_pos[15:0];
                            wr_data  <= sd_dout;
                        end
                        byte_index <= byte_index + 10'd1;
                    end
                end

                ld_next: begin
                    if (current_sector == sector_t'(GAME_SECTORS - 1)) begin
                        state <= ld_complete;
                    end else begin
                        current_sector <= current_sector + 7'd1;
                        state          <= ld_idle;
                    end
                end

                ld_complete: begin
                    // Set once, stays until reset
                    if (!game_loaded && trigger_wr)
                        game_loaded <= 1'b1;
                end

                default: state <= ld_idle;
            endcase
        end
    end

endmodule

// ==== source/game_ram.sv ====
`timescale 1ns/1ns

module game_ram (
    input  logic                 sys_clk,
    input  logic                 wr_en,      // Loader write strobe
    input  cart_pkg::ram_index_t wr_index,
    input  cart_pkg::byte_t      wr_data,
    input  cart_pkg::ram_index_t rd_index,   // Bus side index
    output cart_pkg::byte_t      rd_data
);
    import cart_pkg::*;

    // ==================================================
    // 48 KB game image
    // ==================================================
    byte_t mem [0:ROM_BYTES-1];

    // Loader port
    always_ff @(posedge sys_clk) begin
        if (wr_en && (wr_index < ROM_BYTES)) begin
            mem[wr_index] <= wr_data;
        end
    end

    // Bus port, one cycle latency
    always_ff @(posedge sys_clk) begin
        if (rd_index < ROM_BYTES)
            rd_data <= mem[rd_index];
        else
            rd_data <= 8'hFF;   // Outside the image
    end

endmodule

// ==== source/cart_bus_front.sv ====
`timescale 1ns/1ns

module cart_bus_front (
    input  logic               sys_clk,
    input  logic               sd_reset,
    input  cart_pkg::addr_t    a,          // Console address pins
    input  logic               phi2,
    input  logic               rw,         // 1 = read, 0 = write
    input  logic               halt,       // Low during MARIA DMA
    input  cart_pkg::byte_t    rd_data,    // Game memory read data
    input  logic               game_loaded,
    inout  wire cart_pkg::byte_t d,
    output cart_pkg::addr_t    a_safe,
    output logic               rw_safe,
    output logic               phi2_safe,
    output cart_pkg::byte_t    d_in,
    output cart_pkg::ram_index_t rom_index,
    output logic               rom_read,
    output logic               buf_dir,
    output logic               buf_oe
);
    import cart_pkg::*;

    logic halt_safe;
    logic is_rom;
    logic is_pokey;
    logic is_menu;
    logic cpu_active;
    logic dma_active;
    logic should_drive;
    logic pokey_we;

    // ==================================================
    // Input synchronisation
    // ==================================================
    always_ff @(posedge sys_clk) begin
        a_safe <= a;
        d_in   <= d;   // Write data for the trigger
        if (sd_reset) begin
            phi2_safe <= 1'b0;
            rw_safe   <= 1'b1;   // Idle as read, nothing driven
            halt_safe <= 1'b1;
        end else begin
            phi2_safe <= phi2;
            rw_safe   <= rw;
            halt_safe <= halt;
        end
    end

    // ==================================================
    // Address decode
    // ==================================================
    assign is_rom    = (a_safe >= ROM_BASE);               // $4000-$FFFF
    assign is_pokey  = (a_safe[15:4] == POKEY_PAGE);
    assign is_menu   = (a_safe == MENU_CTRL_ADDR);
    assign rom_index = a_safe - ROM_BASE;                  // 0..49151 inside window
    assign rom_read  = is_rom && rw_safe;

    // CPU cycles are valid with phi2 high, DMA reads run whenever halt is low
    assign cpu_active   = phi2_safe && halt_safe;
    assign dma_active   = !halt_safe;
    assign should_drive = rom_read && (cpu_active || dma_active);
    assign pokey_we     = is_pokey && !rw_safe && phi2_safe;   // Data valid only in phi2

    // ==================================================
    // Buffer control
    // ==================================================
    always_ff @(posedge sys_clk) begin
        if (sd_reset) begin
            buf_dir <= 1'b1;
            buf_oe  <= 1'b1;     // Disabled
        end else begin
            buf_dir <= rw_safe;  // 1 = cart to console
            if (is_menu && !rw_safe)
                buf_oe <= 1'b1;  // Menu control byte stays off the bus
            else if (should_drive || pokey_we)
                buf_oe <= 1'b0;
            else
                buf_oe <= 1'b1;
        end
    end

    // Menu mode has no ROM image, so the window reads as $FF
    assign d = should_drive ? (game_loaded ? rd_data : 8'hFF) : 'z;

endmodule

// ==== source/cart_pkg.sv ====
package cart_pkg;

    // ==================================================
    // Bus and memory types
    // ==================================================
    typedef logic [15:0] addr_t;       // Console address
    typedef logic [7:0]  byte_t;       // Data byte
    typedef logic [15:0] ram_index_t;  // Game memory index
    typedef logic [6:0]  sector_t;     // SD sector number, up to 127

    // ==================================================
    // Console memory map
    // ==================================================
    localparam addr_t      ROM_BASE          = 16'h4000;  // ROM window $4000-$FFFF
    localparam int         ROM_BYTES         = 49152;     // 48 KB game image
    localparam logic [11:0] POKEY_PAGE       = 12'h045;   // POKEY at $0450-$045F
    localparam addr_t      MENU_CTRL_ADDR    = 16'h2200;  // Menu control byte
    localparam addr_t      GAME_TRIGGER_ADDR = 16'h0458;  // POKEY base + 8

    // ==================================================
    // SD image layout
    // ==================================================
    // The .a78 image is a 128-byte header followed by the ROM, so a
    // 48 KB game spans 97 sectors
    localparam int SECTOR_BYTES = 512;
    localparam int HEADER_BYTES = 128;   // Sector 0 only
    localparam int GAME_SECTORS = 97;

    localparam logic [4:0] SD_READY_STATUS = 5'd6;  // Controller idle after init

    // Activity hold after a phi2 edge
    localparam int ACTIVITY_TIMEOUT = 1 << 20;

    // ==================================================
    // Loader FSM
    // ==================================================
    typedef enum logic [2:0] {
        ld_idle,      // Wait for SD controller ready
        ld_start,     // Issue sector read
        ld_wait,      // Wait for controller to go busy
        ld_data,      // Collect sector bytes
        ld_next,      // Advance or finish
        ld_complete   // Image loaded, wait for trigger
    } loader_state_t;

endpackage
